// File: design/cam_usb_pkg.sv
`default_nettype none

package cam_usb_pkg;

  // ==========================================================================
  // widths
  // ==========================================================================
  localparam int CAM_BYTE_W = 8;   // camera / usb byte
  localparam int PIX_W      = 16;  // rgb565 word

  // one camera sample, ov5640 parallel port
  typedef struct packed {
    logic                  vsync;  // frame sync
    logic                  href;   // line valid
    logic [CAM_BYTE_W-1:0] data;   // pixel byte
  } cam_bus_t;

  // usb device controller flags
  typedef struct packed {
    logic online;   // enumerated
    logic usb_rst;  // bus reset seen
    logic suspend;  // bus suspended
  } usb_status_t;

  // usb device controller transmit handshake
  typedef struct packed {
    logic txact;  // in transfer active
    logic txpop;  // byte taken this edge
  } usb_tx_t;

  typedef struct packed {
    logic [CAM_BYTE_W-1:0] hi;  // first camera byte
    logic [CAM_BYTE_W-1:0] lo;  // second camera byte
  } pix_raw_t;

  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } pix_rgb_t;

  // same 16 bits, seen as a byte pair or as colour fields
  typedef union packed {
    pix_raw_t raw;
    pix_rgb_t rgb;
  } pixel_word_u;

  typedef logic [16:0] byte_cnt_t;  // fifo fill in bytes

endpackage

`default_nettype wire

// File: design/cam_pixel_capture.sv
`default_nettype none

module cam_pixel_capture
  import cam_usb_pkg::*;
(
  input  logic        ulpi_clk,
  input  logic        I_rst_n,
  input  cam_bus_t    cam_i,        // camera sample
  input  logic        cam_valid_i,  // sample strobe
  input  logic        flush_i,      // usb bus reset flush
  output logic        pix_wr_o,     // one cycle write strobe
  output pixel_word_u pix_word_o    // r/b swapped word
);

  cam_bus_t              cam_q;      // registered sample
  logic                  cam_vld_q;  // registered strobe
  logic                  phase_q;    // 1 = high byte held
  logic [CAM_BYTE_W-1:0] hi_q;       // held high byte
  logic                  byte_take;  // counted byte this cycle
  pixel_word_u           pair_w;     // raw byte pair
  pixel_word_u           swap_w;     // colour swapped word

  // input sampling stage
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      cam_q     <= '0;
      cam_vld_q <= 1'b0;
    end else begin
      cam_q     <= cam_i;
      cam_vld_q <= cam_valid_i;
    end
  end

  assign byte_take = cam_vld_q & cam_q.href;  // strobe and line valid

  // first byte in the high half, swap r and b fields
  always_comb begin
    pair_w.raw.hi = hi_q;
    pair_w.raw.lo = cam_q.data;
    swap_w.rgb.r  = pair_w.rgb.b;  // blue lands in red slot
    swap_w.rgb.g  = pair_w.rgb.g;  // green stays
    swap_w.rgb.b  = pair_w.rgb.r;
  end

  // pairing phase and write strobe
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      phase_q  <= 1'b0;
      pix_wr_o <= 1'b0;
    end else if (flush_i || cam_q.vsync) begin
      phase_q  <= 1'b0;  // restart on frame or flush
      pix_wr_o <= 1'b0;  // drop a half built pair
    end else begin
      pix_wr_o <= byte_take & phase_q;  // second byte completes word
      if (byte_take) begin
        phase_q <= ~phase_q;
      end
    end
  end

  // byte holding and word output
  always_ff @(posedge ulpi_clk) begin
    if (byte_take && !phase_q) begin
      hi_q <= cam_q.data;
    end
    if (byte_take && phase_q) begin
      pix_word_o <= swap_w;
    end
  end

  // one word per byte pair, so strobes never run back to back
  a_wr_single: assert property (@(posedge ulpi_clk) disable iff (!I_rst_n)
    pix_wr_o |=> !pix_wr_o);

endmodule

`default_nettype wire

// File: design/pixel_byte_fifo.sv
`default_nettype none

module pixel_byte_fifo
  import cam_usb_pkg::*;
#(
  parameter int FIFO_WORDS = 1024  // depth in pixel words
) (
  input  logic                  ulpi_clk,
  input  logic                  I_rst_n,
  input  logic                  wr_i,        // word write strobe
  input  pixel_word_u           word_i,      // word to store
  input  logic                  pop_i,       // head byte taken
  input  logic                  flush_i,     // empty the buffer
  output logic [CAM_BYTE_W-1:0] head_o,      // current byte
  output byte_cnt_t             fill_o,      // bytes held
  output logic                  overflow_o   // sticky, words lost
);

  localparam int AW = (FIFO_WORDS > 1) ? $clog2(FIFO_WORDS) : 1;

  // ==========================================================================
  // storage and pointers
  // ==========================================================================
  pixel_word_u   mem [FIFO_WORDS];  // word store, no reset
  pixel_word_u   head_word;         // word under read pointer
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   words_q;           // words held, partly read one included
  logic          byte_sel_q;        // 0 = low half next
  logic          full;
  logic          wr_ok;             // write accepted
  logic          pop_ok;            // pop accepted
  logic          word_done;         // high half leaves, word freed

  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(FIFO_WORDS - 1)) ? '0 : p + 1'b1;  // wrap at depth
  endfunction

  assign full      = (words_q == (AW+1)'(FIFO_WORDS));
  assign wr_ok     = wr_i & ~full & ~flush_i;            // full drops word
  assign pop_ok    = pop_i & (fill_o != '0) & ~flush_i;  // never pop empty
  assign word_done = pop_ok & byte_sel_q;

  always_ff @(posedge ulpi_clk) begin
    if (wr_ok) begin
      mem[wr_ptr_q] <= word_i;
    end
  end

  assign head_word = mem[rd_ptr_q];
  assign head_o    = byte_sel_q ? head_word.raw.hi : head_word.raw.lo;  // low first

  // ==========================================================================
  // pointer, count and byte select update
  // ==========================================================================
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      words_q    <= '0;
      byte_sel_q <= 1'b0;
      fill_o     <= '0;
    end else if (flush_i) begin
      wr_ptr_q   <= '0;  // flush empties everything
      rd_ptr_q   <= '0;
      words_q    <= '0;
      byte_sel_q <= 1'b0;
      fill_o     <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (word_done) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (pop_ok) begin
        byte_sel_q <= ~byte_sel_q;  // low then high
      end
      words_q <= words_q + (AW+1)'(wr_ok) - (AW+1)'(word_done);
      fill_o  <= fill_o + byte_cnt_t'({wr_ok, 1'b0}) - byte_cnt_t'(pop_ok);  // 2 in, 1 out
    end
  end

  // sticky loss flag, survives flush
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      overflow_o <= 1'b0;
    end else if (wr_i && full && !flush_i) begin
      overflow_o <= 1'b1;
    end
  end

  // the stream controller only forwards pops into a buffered packet
  a_pop_nonempty: assert property (@(posedge ulpi_clk) disable iff (!I_rst_n)
    pop_i |-> (fill_o != '0));

endmodule

`default_nettype wire

// File: design/usb_stream_ctrl.sv
`default_nettype none

module usb_stream_ctrl
  import cam_usb_pkg::*;
#(
  parameter int PKT_BYTES = 512  // bulk packet size
) (
  input  logic        ulpi_clk,
  input  logic        I_rst_n,
  input  byte_cnt_t   fill_i,        // fifo fill in bytes
  input  usb_tx_t     usb_tx_i,      // controller pop handshake
  input  usb_status_t usb_status_i,  // controller flags
  output logic        pop_o,         // pop to fifo
  output logic        flush_o,       // flush fifo and capture
  output logic        cork_o         // hold off the controller
);

  localparam int        CW      = $clog2(PKT_BYTES + 1);
  localparam byte_cnt_t PKT_LVL = byte_cnt_t'(PKT_BYTES);  // release level

  logic          pkt_open_q;  // packet in flight
  logic [CW-1:0] pkt_cnt_q;   // bytes popped in packet
  logic          flush_q;     // registered bus reset
  logic          pkt_last;    // final pop of packet

  assign flush_o  = flush_q;
  assign cork_o   = ~pkt_open_q;                               // corked unless open
  assign pop_o    = usb_tx_i.txpop & pkt_open_q & ~flush_q;    // corked pops ignored
  assign pkt_last = pop_o & (pkt_cnt_q == CW'(PKT_BYTES - 1));

  // ==========================================================================
  // packet gating FSM
  // ==========================================================================
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      flush_q    <= 1'b0;
      pkt_open_q <= 1'b0;
      pkt_cnt_q  <= '0;
    end else begin
      flush_q <= usb_status_i.usb_rst;  // one flush per reset cycle
      if (flush_q) begin
        pkt_open_q <= 1'b0;  // abandon open packet
        pkt_cnt_q  <= '0;
      end else if (!pkt_open_q) begin
        pkt_cnt_q <= '0;
        if (fill_i >= PKT_LVL) begin
          pkt_open_q <= 1'b1;  // full packet buffered
        end
      end else if (pkt_last) begin
        pkt_cnt_q  <= '0;
        pkt_open_q <= (fill_i > PKT_LVL);  // fill excludes this pop, stay open if next is ready
      end else if (pop_o) begin
        pkt_cnt_q <= pkt_cnt_q + 1'b1;
      end
    end
  end

  a_cnt_bound: assert property (@(posedge ulpi_clk) disable iff (!I_rst_n)
    pkt_cnt_q <= CW'(PKT_BYTES));

endmodule

`default_nettype wire

// File: design/status_indicator.sv
`default_nettype none

module status_indicator
  import cam_usb_pkg::*;
#(
  parameter int HALF_PERIOD = 30_000_000  // clocks per heartbeat half
) (
  input  logic        ulpi_clk,
  input  logic        I_rst_n,
  input  usb_status_t usb_status_i,  // controller flags
  output logic [3:0]  led_o          // active low flags and heartbeat
);

  logic [31:0] tick_q;  // heartbeat divider
  logic        beat_q;  // heartbeat level

  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      tick_q <= '0;
      beat_q <= 1'b0;
    end else if (tick_q >= 32'(HALF_PERIOD - 1)) begin
      tick_q <= '0;
      beat_q <= ~beat_q;  // toggle each half period
    end else begin
      tick_q <= tick_q + 32'd1;
    end
  end

  assign led_o[0] = ~usb_status_i.online;   // lit when connected
  assign led_o[1] = ~usb_status_i.usb_rst;  // lit during bus reset
  assign led_o[2] = ~usb_status_i.suspend;
  assign led_o[3] = beat_q;

endmodule

`default_nettype wire

// File: design/cam_usb_bridge_top.sv
`default_nettype none

module cam_usb_bridge_top
  import cam_usb_pkg::*;
#(
  parameter int PKT_BYTES   = 512,         // bulk packet bytes
  parameter int FIFO_WORDS  = 1024,        // buffer depth in words
  parameter int HALF_PERIOD = 30_000_000   // heartbeat half period
) (
  input  logic                  ulpi_clk,
  input  logic                  I_rst_n,
  input  cam_bus_t              cam_i,         // ov5640 sample
  input  logic                  cam_valid_i,   // sample strobe
  input  usb_status_t           usb_status_i,  // controller flags
  input  usb_tx_t               usb_tx_i,      // controller pop handshake
  output logic [CAM_BYTE_W-1:0] tx_data_o,     // bulk in byte
  output logic                  cork_o,        // no packet ready
  output logic                  overflow_o,    // pixels lost
  output logic [3:0]            led_o
);

  // ==========================================================================
  // internal links
  // ==========================================================================
  logic        pix_wr;    // capture write strobe
  pixel_word_u pix_word;  // swapped pixel
  logic        fifo_pop;  // gated pop
  logic        flush;     // bus reset flush
  byte_cnt_t   fill;      // buffered bytes

  cam_pixel_capture i_capture (
    .ulpi_clk    (ulpi_clk),
    .I_rst_n     (I_rst_n),
    .cam_i       (cam_i),
    .cam_valid_i (cam_valid_i),
    .flush_i     (flush),
    .pix_wr_o    (pix_wr),
    .pix_word_o  (pix_word)
  );

  pixel_byte_fifo #(
    .FIFO_WORDS (FIFO_WORDS)
  ) i_fifo (
    .ulpi_clk   (ulpi_clk),
    .I_rst_n    (I_rst_n),
    .wr_i       (pix_wr),
    .word_i     (pix_word),
    .pop_i      (fifo_pop),
    .flush_i    (flush),
    .head_o     (tx_data_o),  // head byte straight to controller
    .fill_o     (fill),
    .overflow_o (overflow_o)
  );

  usb_stream_ctrl #(
    .PKT_BYTES (PKT_BYTES)
  ) i_stream (
    .ulpi_clk     (ulpi_clk),
    .I_rst_n      (I_rst_n),
    .fill_i       (fill),
    .usb_tx_i     (usb_tx_i),
    .usb_status_i (usb_status_i),
    .pop_o        (fifo_pop),
    .flush_o      (flush),
    .cork_o       (cork_o)
  );

  status_indicator #(
    .HALF_PERIOD (HALF_PERIOD)
  ) i_status (
    .ulpi_clk     (ulpi_clk),
    .I_rst_n      (I_rst_n),
    .usb_status_i (usb_status_i),
    .led_o        (led_o)
  );

endmodule

`default_nettype wire

// File: tb/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ============================================================================
// pixel source
// ============================================================================
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois, taps 16 14 13 11
endfunction

task automatic draw_pixel(output logic [PIX_W-1:0] w);
  w = '0;
  for (int i = 0; i < PIX_W; i++) begin
    w      = {w[PIX_W-2:0], lfsr_q[0]};  // one step per bit
    lfsr_q = lfsr_next(lfsr_q);
  end
endtask

// first byte is hi, r sits in 15:11 and b in 4:0
task automatic expect_pixel(input logic [PIX_W-1:0] w);
  logic [PIX_W-1:0] sw;
  sw = {w[4:0], w[10:5], w[15:11]};  // red and blue exchanged
  exp_q.push_back(sw[7:0]);          // low byte leaves first
  exp_q.push_back(sw[15:8]);
endtask

// ============================================================================
// typed compares
// ============================================================================
task automatic check_byte(input logic [CAM_BYTE_W-1:0] got, input logic [CAM_BYTE_W-1:0] exp,
                          input string what);
  if (got !== exp) begin
    flag_mismatch($sformatf("%s got %02h expected %02h", what, got, exp));
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    flag_mismatch($sformatf("%s got %b expected %b", what, got, exp));
  end
endtask

task automatic check_leds(input logic [3:0] got, input logic [3:0] exp);
  if (got !== exp) begin
    flag_mismatch($sformatf("led_o got %b expected %b", got, exp));
  end
endtask

// ============================================================================
// camera drive
// ============================================================================
task automatic send_byte(input logic [CAM_BYTE_W-1:0] d);
  @(posedge ulpi_clk);
  #DRV_DLY;
  cam_i.vsync = 1'b0;
  cam_i.href  = 1'b1;
  cam_i.data  = d;
  cam_valid_i = 1'b1;  // held until the next drive
endtask

task automatic cam_idle();
  @(posedge ulpi_clk);
  #DRV_DLY;
  cam_valid_i = 1'b0;
  cam_i.href  = 1'b0;
endtask

task automatic send_pixel(input logic [PIX_W-1:0] w);
  send_byte(w[15:8]);  // high byte first
  send_byte(w[7:0]);
endtask

task automatic new_pixel(input bit keep);
  logic [PIX_W-1:0] w;
  draw_pixel(w);
  send_pixel(w);
  if (keep) begin
    expect_pixel(w);  // dropped pixels never queued
  end
endtask

`endif

// File: tb/tb_cam_usb_bridge.sv
`default_nettype none

module tb_cam_usb_bridge
  import cam_usb_pkg::*;
;

  localparam int CLK_HALF   = 4;   // 8 unit period
  localparam int DRV_DLY    = 1;   // drive skew after rising edge
  localparam int RST_CYCLES = 10;
  localparam int PKT        = 16;  // bytes per packet
  localparam int HB_HALF    = 20;  // heartbeat half period
  localparam int WATCHDOG_CYCLES = RST_CYCLES + 10 + 60 + 70 + 110 + 80 + 120 + 200;

  logic                  ulpi_clk;
  logic                  I_rst_n;
  cam_bus_t              cam_i;
  logic                  cam_valid_i;
  usb_status_t           usb_status;
  usb_tx_t               usb_tx;
  logic [CAM_BYTE_W-1:0] tx_data_o;
  logic                  cork_o;
  logic                  overflow_o;
  logic [3:0]            led_o;

  logic [15:0]           lfsr_q;          // pixel source state
  logic [CAM_BYTE_W-1:0] exp_q[$];        // bytes the controller should see
  logic                  pop_en;          // controller pops when uncorked
  logic                  idle_pop;        // txpop held regardless of cork
  int                    rx_cnt;          // bytes taken by controller
  int                    err_cnt;

  task automatic flag_mismatch(input string msg);
    err_cnt++;
    $display("ERR %0t: %s", $time, msg);
    $display("TEST FAIL");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic abort_run(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "run aborted");
  endtask

  `include "tb_checks.svh"

  cam_usb_bridge_top #(
    .PKT_BYTES   (PKT),
    .FIFO_WORDS  (16),
    .HALF_PERIOD (HB_HALF)
  ) i_dut (
    .ulpi_clk     (ulpi_clk),
    .I_rst_n      (I_rst_n),
    .cam_i        (cam_i),
    .cam_valid_i  (cam_valid_i),
    .usb_status_i (usb_status),
    .usb_tx_i     (usb_tx),
    .tx_data_o    (tx_data_o),
    .cork_o       (cork_o),
    .overflow_o   (overflow_o),
    .led_o        (led_o)
  );

  initial begin
    ulpi_clk = 1'b0;
    forever #CLK_HALF ulpi_clk = ~ulpi_clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ulpi_clk);
    abort_run($sformatf("watchdog expired after %0d cycles, a test hung", WATCHDOG_CYCLES));
  end

  // ==========================================================================
  // usb device controller model
  // ==========================================================================
  initial begin
    forever begin
      @(posedge ulpi_clk);
      #DRV_DLY;
      usb_tx.txpop = idle_pop | (pop_en & ~cork_o);
      usb_tx.txact = ~cork_o;                 // in transfer while uncorked
      if (usb_tx.txpop && !cork_o) begin      // byte taken at next edge
        if (exp_q.size() == 0) begin
          abort_run("controller model took a byte that no test expected");
        end else begin
          check_byte(tx_data_o, exp_q.pop_front(), $sformatf("bulk in byte %0d", rx_cnt));
          rx_cnt++;
        end
      end
    end
  end

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(posedge ulpi_clk);
      n++;
      if (n > max_cycles) begin
        abort_run("expected bytes never left the bridge");
      end
    end
    repeat (2) @(posedge ulpi_clk);
    #(2 * DRV_DLY);
    check_flag(cork_o, 1'b1, "cork after packet");  // packet closed, nothing left
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================
  task automatic verify_reset_state();
    check_flag(cork_o, 1'b1, "cork after reset");
    check_flag(overflow_o, 1'b0, "overflow after reset");
    check_leds(led_o, 4'b0111);  // beat low, all flags off
  endtask

  task automatic stream_byte_order();
    for (int i = 0; i < PKT / 2; i++) begin
      new_pixel(1'b1);
    end
    cam_idle();                                  // edge that samples final byte
    for (int k = 0; k < 4; k++) begin
      if (k > 0) begin
        @(posedge ulpi_clk);
        #DRV_DLY;
      end
      check_flag(cork_o, (k < 3) ? 1'b1 : 1'b0, $sformatf("cork %0d cycles on", k));
    end
    wait_drained(40);
  endtask

  task automatic hold_below_threshold();
    for (int i = 0; i < PKT / 2 - 1; i++) begin
      new_pixel(1'b1);
    end
    cam_idle();
    idle_pop = 1'b1;                             // pops while corked
    repeat (12) begin
      @(posedge ulpi_clk);
      #(2 * DRV_DLY);
      check_flag(cork_o, 1'b1, "cork with 7 pixels");
      check_byte(tx_data_o, exp_q[0], "head while corked");  // nothing consumed
    end
    idle_pop = 1'b0;
    new_pixel(1'b1);                             // eighth pixel opens packet
    cam_idle();
    wait_drained(40);
  endtask

  task automatic drop_on_overflow();
    pop_en = 1'b0;
    for (int i = 0; i < 16; i++) begin
      new_pixel(1'b1);
    end
    cam_idle();
    repeat (3) @(posedge ulpi_clk);
    #(2 * DRV_DLY);
    check_flag(overflow_o, 1'b0, "overflow at exactly full");
    check_flag(cork_o, 1'b0, "cork with full buffer");
    for (int i = 0; i < 4; i++) begin
      new_pixel(1'b0);                           // lost to a full buffer
    end
    cam_idle();
    repeat (3) @(posedge ulpi_clk);
    #(2 * DRV_DLY);
    check_flag(overflow_o, 1'b1, "overflow after drop");
    pop_en = 1'b1;
    wait_drained(80);                            // two packets of 16
    check_flag(overflow_o, 1'b1, "overflow stays set");
  endtask

  task automatic flush_and_resync();
    for (int i = 0; i < 5; i++) begin
      new_pixel(1'b0);                           // flushed before read
    end
    send_byte(8'hA5);                            // lone high byte
    cam_idle();
    @(posedge ulpi_clk);
    #DRV_DLY;
    usb_status.usb_rst = 1'b1;
    @(posedge ulpi_clk);
    #DRV_DLY;
    usb_status.usb_rst = 1'b0;
    cam_i.vsync = 1'b1;                          // frame start
    @(posedge ulpi_clk);
    #DRV_DLY;
    cam_i.vsync = 1'b0;
    repeat (4) @(posedge ulpi_clk);
    #(2 * DRV_DLY);
    check_flag(cork_o, 1'b1, "cork after flush");
    for (int i = 0; i < PKT / 2; i++) begin
      new_pixel(1'b1);
    end
    cam_idle();
    wait_drained(40);
  endtask

  task automatic blink_and_leds();
    logic prev;
    logic beat;
    int   n;
    prev = led_o[3];
    n    = 0;
    do begin                                     // find a toggle edge
      @(posedge ulpi_clk);
      #(2 * DRV_DLY);
      n++;
      if (n > 3 * HB_HALF) begin
        abort_run("heartbeat never toggled");
      end
    end while (led_o[3] == prev);
    beat = led_o[3];
    for (int p = 0; p < 3; p++) begin
      for (int c = 1; c <= HB_HALF; c++) begin
        @(posedge ulpi_clk);
        #DRV_DLY;
        usb_status = usb_status_t'(3'(c + p));   // walk all flag combos
        #DRV_DLY;
        if (c == HB_HALF) begin
          beat = ~beat;
        end
        check_leds(led_o, {beat, ~usb_status.suspend, ~usb_status.usb_rst,
                           ~usb_status.online});
      end
    end
    usb_status = '0;
  endtask

  initial begin
    I_rst_n     = 1'b0;
    cam_i       = '0;
    cam_valid_i = 1'b0;
    usb_status  = '0;
    usb_tx      = '0;
    lfsr_q      = 16'd35706;
    pop_en      = 1'b0;
    idle_pop    = 1'b0;
    rx_cnt      = 0;
    err_cnt     = 0;
    repeat (RST_CYCLES) @(posedge ulpi_clk);
    #DRV_DLY;
    I_rst_n = 1'b1;                              // release away from edge
    #DRV_DLY;
    verify_reset_state();
    pop_en = 1'b1;
    stream_byte_order();
    hold_below_threshold();
    drop_on_overflow();
    flush_and_resync();
    blink_and_leds();
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+tb
design/cam_usb_pkg.sv
design/cam_pixel_capture.sv
design/pixel_byte_fifo.sv
design/usb_stream_ctrl.sv
design/status_indicator.sv
design/cam_usb_bridge_top.sv
tb/tb_cam_usb_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator.
# Exit status is nonzero when the run fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module tb_cam_usb_bridge \
  -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if ! grep -q "TEST PASS" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
exit 0
